// ==== logic/cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// data path and byte address width.
`define CPU_WORD_WIDTH 32

// word address into the RAM slices, 512 words.
`define CPU_RAM_ADDR_WIDTH 9

// one embedded RAM slice holds a nibble.
`define CPU_SLICE_WIDTH 4

// LED display.
`define CPU_DISPLAY_WIDTH 16
`define CPU_DISPLAY_ADDR 32'h0000_07fe

`endif

// ==== logic/cpu_pkg.sv ====
`default_nettype none

`include "cpu_defines.svh"

package cpu_pkg;

    typedef enum logic [3:0] {
        LDI = 4'h0, // acc = zero-extended operand.
        LDA = 4'h1,
        STA = 4'h2,
        ADD = 4'h3,
        SUB = 4'h4,
        JMP = 4'h5,
        JZ  = 4'h6, // jump when acc is zero.
        HLT = 4'h7
    } opcode_e;

    typedef enum logic [2:0] {
        FETCH,
        FETCH_WAIT,
        FETCH_DATA,
        EXECUTE,
        OPERAND_WAIT,
        OPERAND_DATA,
        HALTED
    } state_e;

    typedef struct packed {
        opcode_e     opcode;
        logic [11:0] reserved;
        logic [15:0] operand; // byte address or immediate.
    } instr_t;

    typedef struct packed {
        logic                       enable;
        logic                       write;
        logic [`CPU_WORD_WIDTH-1:0] addr;
        logic [`CPU_WORD_WIDTH-1:0] data;
    } mem_req_t;

endpackage

`default_nettype wire

// ==== logic/eab_ram.sv ====
`default_nettype none
`timescale 1ns/1ns

module eab_ram #(
    parameter int WIDTH      = 4,
    parameter int ADDR_WIDTH = 9
) (
    input  wire logic                  clk,
    input  wire logic                  enable,
    input  wire logic                  we,
    input  wire logic [ADDR_WIDTH-1:0] address,
    input  wire logic [WIDTH-1:0]      data,
    output logic      [WIDTH-1:0]      q
);

    localparam int DEPTH = 1 << ADDR_WIDTH;

    logic [WIDTH-1:0]      mem [DEPTH];
    logic [ADDR_WIDTH-1:0] addr_reg;

    // both the address and output registers only step on enabled edges.
    always_ff @(posedge clk) begin
        if (enable) begin
            addr_reg <= address;
            q        <= mem[addr_reg]; // read is one edge behind the address.
            if (we) begin
                mem[address] <= data;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/memory.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "cpu_defines.svh"

module memory (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire cpu_pkg::mem_req_t            req,
    output logic [`CPU_WORD_WIDTH-1:0]        rdata,
    output logic [`CPU_DISPLAY_WIDTH-1:0]     display
);

    localparam int NUM_SLICES = `CPU_WORD_WIDTH / `CPU_SLICE_WIDTH;

    logic [`CPU_RAM_ADDR_WIDTH-1:0] word_addr;
    logic                           display_hit;

    assign word_addr   = req.addr[`CPU_RAM_ADDR_WIDTH+1:2]; // byte address 10:2.
    assign display_hit = req.enable && req.write && (req.addr == `CPU_DISPLAY_ADDR);

    // slice 0 carries the top nibble.
    for (genvar i = 0; i < NUM_SLICES; i++) begin : g_slice
        localparam int MSB = `CPU_WORD_WIDTH - 1 - i * `CPU_SLICE_WIDTH;

        eab_ram #(
            .WIDTH      (`CPU_SLICE_WIDTH),
            .ADDR_WIDTH (`CPU_RAM_ADDR_WIDTH)
        ) u_slice (
            .clk     (clk),
            .enable  (req.enable),
            .we      (req.write),
            .address (word_addr),
            .data    (req.data[MSB -: `CPU_SLICE_WIDTH]),
            .q       (rdata[MSB -: `CPU_SLICE_WIDTH])
        );
    end

    // LEDs are active low, so all ones is dark.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            display <= '1;
        end else if (display_hit) begin
            display <= ~req.data[`CPU_DISPLAY_WIDTH-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== logic/cpu_core.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "cpu_defines.svh"

module cpu_core (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire logic                         run,
    output cpu_pkg::mem_req_t                 mem_req,
    input  wire logic [`CPU_WORD_WIDTH-1:0]   rdata,
    output logic                              halted
);

    cpu_pkg::state_e              state;
    cpu_pkg::instr_t              ir;
    logic [`CPU_WORD_WIDTH-1:0]   pc;
    logic [`CPU_WORD_WIDTH-1:0]   acc;
    logic [`CPU_WORD_WIDTH-1:0]   operand_ext;
    logic                         fetching;
    logic                         branch_taken;

    assign operand_ext = `CPU_WORD_WIDTH'(ir.operand); // zero extended.

    assign fetching = (state == cpu_pkg::FETCH) ||
                      (state == cpu_pkg::FETCH_WAIT) ||
                      (state == cpu_pkg::FETCH_DATA);

    // only meaningful while in EXECUTE.
    assign branch_taken = (ir.opcode == cpu_pkg::JMP) ||
                          ((ir.opcode == cpu_pkg::JZ) && (acc == '0));

    assign halted = (state == cpu_pkg::HALTED);

    // enable stays high in every running state so reads take two clocks.
    always_comb begin
        mem_req.enable = run && (state != cpu_pkg::HALTED);
        mem_req.write  = (state == cpu_pkg::EXECUTE) && (ir.opcode == cpu_pkg::STA);
        mem_req.addr   = fetching ? pc : operand_ext;
        mem_req.data   = acc;
    end

    // instruction register, loaded once the fetched word is on rdata.
    always_ff @(posedge clk) begin
        if (run && (state == cpu_pkg::FETCH_DATA)) begin
            ir <= cpu_pkg::instr_t'(rdata);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= cpu_pkg::FETCH;
            pc    <= '0;
            acc   <= '0;
        end else if (run) begin
            case (state)
                cpu_pkg::FETCH: begin
                    state <= cpu_pkg::FETCH_WAIT;
                end
                cpu_pkg::FETCH_WAIT: begin
                    state <= cpu_pkg::FETCH_DATA;
                end
                cpu_pkg::FETCH_DATA: begin
                    state <= cpu_pkg::EXECUTE;
                end
                cpu_pkg::EXECUTE: begin
                    if (branch_taken) begin
                        pc <= operand_ext;
                    end else begin
                        pc <= pc + `CPU_WORD_WIDTH'(4);
                    end
                    case (ir.opcode)
                        cpu_pkg::LDI: begin
                            acc   <= operand_ext;
                            state <= cpu_pkg::FETCH;
                        end
                        cpu_pkg::STA,
                        cpu_pkg::JMP,
                        cpu_pkg::JZ: begin
                            state <= cpu_pkg::FETCH; // store issued this cycle.
                        end
                        cpu_pkg::LDA,
                        cpu_pkg::ADD,
                        cpu_pkg::SUB: begin
                            state <= cpu_pkg::OPERAND_WAIT;
                        end
                        default: begin
                            state <= cpu_pkg::HALTED; // HLT and unused codes.
                        end
                    endcase
                end
                cpu_pkg::OPERAND_WAIT: begin
                    state <= cpu_pkg::OPERAND_DATA;
                end
                cpu_pkg::OPERAND_DATA: begin
                    case (ir.opcode)
                        cpu_pkg::LDA: acc <= rdata;
                        cpu_pkg::ADD: acc <= acc + rdata;
                        cpu_pkg::SUB: acc <= acc - rdata;
                        default:      acc <= acc;
                    endcase
                    state <= cpu_pkg::FETCH;
                end
                cpu_pkg::HALTED: begin
                    state <= cpu_pkg::HALTED; // only reset leaves.
                end
                default: begin
                    state <= cpu_pkg::FETCH;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/cpu_top.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "cpu_defines.svh"

module cpu_top (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire logic                         run,
    input  wire logic                         load_write,
    input  wire logic [`CPU_WORD_WIDTH-1:0]   load_addr,
    input  wire logic [`CPU_WORD_WIDTH-1:0]   load_data,
    output logic      [`CPU_DISPLAY_WIDTH-1:0] display,
    output logic                              halted
);

    cpu_pkg::mem_req_t            core_req;
    cpu_pkg::mem_req_t            bus_req;
    logic [`CPU_WORD_WIDTH-1:0]   rdata;

    // load port owns the memory while the core is held.
    always_comb begin
        if (run) begin
            bus_req = core_req;
        end else begin
            bus_req.enable = load_write;
            bus_req.write  = load_write;
            bus_req.addr   = load_addr;
            bus_req.data   = load_data;
        end
    end

    cpu_core u_core (
        .clk     (clk),
        .rst_n   (rst_n),
        .run     (run),
        .mem_req (core_req),
        .rdata   (rdata),
        .halted  (halted)
    );

    memory u_memory (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (bus_req),
        .rdata   (rdata),
        .display (display)
    );

endmodule

`default_nettype wire

// ==== sim/cpu_tb.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "cpu_defines.svh"

module cpu_tb;

    localparam string STIM_FILE    = "sim/cpu_stimulus.txt";
    localparam int    RESET_CYCLES = 3;
    localparam int    RUN_TIMEOUT  = 2000;
    localparam int    IDLE_CYCLES  = 40;

    logic                          clk = 1'b0;
    logic                          rst_n;
    logic                          run;
    logic                          load_write;
    logic [`CPU_WORD_WIDTH-1:0]    load_addr;
    logic [`CPU_WORD_WIDTH-1:0]    load_data;
    logic [`CPU_DISPLAY_WIDTH-1:0] display;
    logic                          halted;

    logic [31:0] prog_addr[$];
    logic [31:0] prog_data[$];
    logic [31:0] expected_acc[$]; // accumulator values stored to the display.
    int          programs_run;

    cpu_top uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .run        (run),
        .load_write (load_write),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .display    (display),
        .halted     (halted)
    );

    always #5 clk = ~clk;

    task automatic abort_run(input string why);
        $display("TEST FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] want);
        if (actual !== want) begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, actual, want);
            abort_run("a checked value did not match its expected value");
        end
    endtask

    // reset state is checked before every program.
    task automatic apply_reset();
        @(negedge clk);
        rst_n      = 1'b0;
        run        = 1'b0;
        load_write = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("display", 32'(display), 32'h0000_ffff);
        check_value("halted", 32'(halted), 32'h0);
    endtask

    task automatic load_program();
        for (int i = 0; i < prog_addr.size(); i++) begin
            load_write = 1'b1;
            load_addr  = prog_addr[i];
            load_data  = prog_data[i];
            @(negedge clk);
        end
        load_write = 1'b0;
    endtask

    task automatic run_program(input logic pauses);
        int                            cycles;
        int                            seen;
        int                            gap;
        int                            pause_count;
        logic                          done;
        logic [`CPU_DISPLAY_WIDTH-1:0] last_display;
        logic [`CPU_DISPLAY_WIDTH-1:0] want;
        cycles       = 0;
        seen         = 0;
        gap          = 0;
        pause_count  = 0;
        done         = 1'b0;
        last_display = display;
        run          = 1'b1;
        while (!done) begin
            @(negedge clk);
            cycles++;
            if (cycles > RUN_TIMEOUT) begin
                abort_run("the program did not halt within the cycle limit");
            end
            if (display != last_display) begin
                if (seen >= expected_acc.size()) begin
                    abort_run("the display changed more often than the stimulus file expects");
                end
                want = ~expected_acc[seen][`CPU_DISPLAY_WIDTH-1:0]; // LEDs are active low.
                check_value("display", 32'(display), 32'(want));
                seen++;
                last_display = display;
            end
            if (halted) begin
                done = 1'b1;
            end else if (pauses) begin
                if (gap > 0) begin
                    gap--;
                    if (gap == 0) begin
                        run = 1'b1;
                    end
                end else if ($urandom % 5 == 0) begin
                    run = 1'b0;
                    gap = 1 + int'($urandom % 4);
                    pause_count++;
                end
            end
        end
        if (pauses && pause_count == 0) begin
            abort_run("the paused run never dropped the run level");
        end
        check_value("display update count", 32'(seen), 32'(expected_acc.size()));
        // core must stay stopped and leave the LEDs alone.
        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            check_value("halted", 32'(halted), 32'h1);
            check_value("display", 32'(display), 32'(last_display));
        end
        run = 1'b0;
    endtask

    initial begin
        int          fd;
        int          count;
        string       line;
        logic [31:0] a;
        logic [31:0] b;
        void'($urandom(32'h67ff));
        rst_n        = 1'b0;
        run          = 1'b0;
        load_write   = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        programs_run = 0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            abort_run("cannot open the stimulus file");
        end
        while ($fgets(line, fd) != 0) begin
            case (line[0])
                "W": begin
                    count = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
                    if (count != 2) begin
                        abort_run("a program word record in the stimulus file is malformed");
                    end
                    prog_addr.push_back(a);
                    prog_data.push_back(b);
                end
                "E": begin
                    count = $sscanf(line.substr(1, line.len() - 1), "%h", a);
                    if (count != 1) begin
                        abort_run("an expected value record in the stimulus file is malformed");
                    end
                    expected_acc.push_back(a);
                end
                "P": begin
                    count = $sscanf(line.substr(1, line.len() - 1), "%h", a);
                    if (count != 1 || prog_addr.size() == 0) begin
                        abort_run("a program end record in the stimulus file is malformed");
                    end
                    apply_reset();
                    load_program();
                    run_program(a[0]);
                    programs_run++;
                    prog_addr.delete();
                    prog_data.delete();
                    expected_acc.delete();
                end
                default: begin
                end
            endcase
        end
        $fclose(fd);
        if (programs_run == 0) begin
            abort_run("the stimulus file holds no programs");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== sim/cpu_stimulus.txt ====
# W <byte address> <word>: load one word, E <acc>: value stored to 0x7fe, shown inverted.
# P <flag>: end of program, flag 1 runs it with random run-low pauses. All numbers hex.

# arithmetic with wrap-around
W 00000000 00001234  LDI 0x1234
W 00000004 30000100  ADD [0x100]
W 00000008 200007fe  STA display
W 0000000c 40000104  SUB [0x104]
W 00000010 200007fe  STA display
W 00000014 00000000  LDI 0
W 00000018 40000108  SUB [0x108]
W 0000001c 200007fe  STA display
W 00000020 70000000  HLT
W 00000100 0000f00f
W 00000104 00010300
W 00000108 00000001
E 00010243
E ffffff43
E ffffffff
P 0

# memory round trip through the nibble slices
W 00000000 0000a5c3  LDI 0xa5c3
W 00000004 20000200  STA [0x200]
W 00000008 00000000  LDI 0
W 0000000c 10000200  LDA [0x200]
W 00000010 200007fe  STA display
W 00000014 10000204  LDA [0x204]
W 00000018 20000208  STA [0x208]
W 0000001c 00000000  LDI 0
W 00000020 10000208  LDA [0x208]
W 00000024 200007fe  STA display
W 00000028 40000204  SUB [0x204]
W 0000002c 200007fe  STA display
W 00000030 70000000  HLT
W 00000204 9e376b1d
E 0000a5c3
E 9e376b1d
E 00000000
P 0

# countdown loop
W 00000000 00000003  LDI 3
W 00000004 200007fe  STA display
W 00000008 60000014  JZ 0x14
W 0000000c 40000100  SUB [0x100]
W 00000010 50000004  JMP 0x04
W 00000014 70000000  HLT
W 00000100 00000001
E 00000003
E 00000002
E 00000001
E 00000000
P 0

# same countdown with pauses
W 00000000 00000003  LDI 3
W 00000004 200007fe  STA display
W 00000008 60000014  JZ 0x14
W 0000000c 40000100  SUB [0x100]
W 00000010 50000004  JMP 0x04
W 00000014 70000000  HLT
W 00000100 00000001
E 00000003
E 00000002
E 00000001
E 00000000
P 1

// ==== build.f ====
+incdir+logic
logic/cpu_pkg.sv
logic/eab_ram.sv
logic/memory.sv
logic/cpu_core.sv
logic/cpu_top.sv
sim/cpu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(wildcard logic/*.sv logic/*.svh sim/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR, TOP, FILELIST, OBJ_DIR, VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the simulator exits non-zero on any failure.
test: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
